/* logic/bank_mux.sv */
// **************************************
// one bank shared by its wide lane and the narrow port
// narrow wins and read data goes to the owner next cycle
// **************************************

`timescale 1ns/1ns

module bank_mux (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tcdm_pkg::word_req_t  wide_req_i,
  input  logic                 wide_valid_i,
  output logic                 wide_gnt_o,
  output tcdm_pkg::tcdm_word_t wide_rdata_o,
  input  tcdm_pkg::word_req_t  nar_req_i,
  input  logic                 nar_valid_i,
  output logic                 nar_gnt_o,
  output tcdm_pkg::tcdm_word_t nar_rdata_o,
  output logic                 nar_r_valid_o,
  output logic                 mem_en_o,
  output logic                 mem_wen_o,
  output tcdm_pkg::row_t       mem_row_o,
  output tcdm_pkg::tcdm_be_t   mem_be_o,
  output tcdm_pkg::tcdm_word_t mem_wdata_o,
  input  tcdm_pkg::tcdm_word_t mem_rdata_i
);

  import tcdm_pkg::*;

  word_req_t winner;
  owner_e    owner_d;
  owner_e    owner_q;

  // fixed priority with the narrow port first
  assign nar_gnt_o  = nar_valid_i;
  assign wide_gnt_o = wide_valid_i & ~nar_valid_i;

  assign winner = nar_valid_i ? nar_req_i : wide_req_i;

  assign mem_en_o    = nar_valid_i | wide_valid_i;
  assign mem_wen_o   = winner.wen;  // high means read
  assign mem_be_o    = winner.be;
  assign mem_wdata_o = winner.data;

  // row bits sit above the bank bits and the byte offset
  assign mem_row_o = winner.add[2 + $bits(bank_sel_t) +: $bits(row_t)];

  always_comb begin
    if (nar_valid_i) begin
      owner_d = OWNER_NARROW;
    end else if (wide_valid_i) begin
      owner_d = OWNER_WIDE;
    end else begin
      owner_d = OWNER_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OWNER_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // only the owner sees the data
  assign wide_rdata_o  = (owner_q == OWNER_WIDE) ? mem_rdata_i : '0;
  assign nar_rdata_o   = (owner_q == OWNER_NARROW) ? mem_rdata_i : '0;
  assign nar_r_valid_o = (owner_q == OWNER_NARROW);

  // upper address bits would alias onto a lower row
  a_addr_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_en_o |-> (winner.add >> (2 + $bits(bank_sel_t) + $bits(row_t))) == '0
  );

endmodule

/* logic/lane_reorder.sv */
// **************************************
// rotates wide lanes onto consecutive banks
// grants the wide access only when every touched bank grants
// and hands back lane-ordered read data one cycle later
// **************************************

`timescale 1ns/1ns

`include "tcdm_params.svh"

module lane_reorder (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  tcdm_pkg::word_req_t [`TCDM_NB_LANES-1:0] lane_req_i,
  input  logic                [`TCDM_NB_LANES-1:0] lane_valid_i,
  input  tcdm_pkg::bank_sel_t                      order_i,
  output logic                                     wide_gnt_o,
  output tcdm_pkg::wide_rsp_t                      wide_rsp_o,
  output logic                                     wide_r_valid_o,
  output tcdm_pkg::word_req_t [`TCDM_NB_BANKS-1:0] bank_req_o,
  output logic                [`TCDM_NB_BANKS-1:0] bank_valid_o,
  input  logic                [`TCDM_NB_BANKS-1:0] bank_gnt_i,
  input  tcdm_pkg::tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_rdata_i
);

  import tcdm_pkg::*;

  bank_sel_t [`TCDM_NB_LANES-1:0] lane_bank;  // target bank per lane
  bank_sel_t                      order_q;
  logic                           accepted_q;

  // lane i lands on bank order + i modulo the bank count
  always_comb begin
    for (int i = 0; i < `TCDM_NB_LANES; i++) begin
      lane_bank[i] = order_i + bank_sel_t'(i);
    end
  end

  // banks without a lane stay idle
  always_comb begin
    for (int k = 0; k < `TCDM_NB_BANKS; k++) begin
      bank_req_o[k]   = '0;
      bank_valid_o[k] = 1'b0;
      for (int i = 0; i < `TCDM_NB_LANES; i++) begin
        if (lane_bank[i] == bank_sel_t'(k)) begin
          bank_req_o[k]   = lane_req_i[i];
          bank_valid_o[k] = lane_valid_i[i];
        end
      end
    end
  end

  // all or nothing
  // a partial grant is dropped here and the initiator replays the whole access
  assign wide_gnt_o = (|lane_valid_i) & (&(~bank_valid_o | bank_gnt_i));

  // rotation kept for the one-cycle read back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q    <= '0;
      accepted_q <= 1'b0;
    end else begin
      accepted_q <= wide_gnt_o;
      if (wide_gnt_o) begin
        order_q <= order_i;
      end
    end
  end

  // undo the rotation so lane 0 comes first
  always_comb begin
    for (int i = 0; i < `TCDM_NB_LANES; i++) begin
      wide_rsp_o.r_data[i] = bank_rdata_i[order_q + bank_sel_t'(i)];
    end
  end

  assign wide_r_valid_o = accepted_q;  // reads and writes alike

  // initiator holds the whole access until it is granted
  a_hold_until_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|lane_valid_i) && !wide_gnt_o |=> $stable(lane_valid_i) && $stable(lane_req_i)
  );

endmodule

/* logic/tcdm_bank.sv */
// **************************************
// single-port word memory of one bank
// byte-enable writes, read data one cycle after en
// **************************************

`timescale 1ns/1ns

`include "tcdm_params.svh"

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  logic                 wen_i,  // high means read
  input  tcdm_pkg::row_t       row_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  tcdm_pkg::tcdm_word_t wdata_i,
  output tcdm_pkg::tcdm_word_t rdata_o
);

  import tcdm_pkg::*;

  tcdm_word_t mem [`TCDM_BANK_WORDS];
  tcdm_word_t rdata_q;
  logic       we;

  // writes are blocked while reset is asserted
  assign we = en_i & ~wen_i & rst_ni;

  always_ff @(posedge clk_i) begin
    if (we) begin
      for (int b = 0; b < $bits(tcdm_be_t); b++) begin
        if (be_i[b]) begin
          mem[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read before write on the same row
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_q <= mem[row_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* logic/tcdm_params.svh */
// **************************************
// sizing of the banked scratchpad
// include wherever lane, bank or row counts are needed
// **************************************

`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// words moved by one wide access, not more than the bank count
`define TCDM_NB_LANES 4

// word-interleaved banks, power of two
`define TCDM_NB_BANKS 8

// depth of every bank in words
`define TCDM_BANK_WORDS 64

`endif

/* logic/tcdm_pkg.sv */
// **************************************
// types shared by the scratchpad blocks
// import inside a module body, scoped names in port lists
// **************************************

`include "tcdm_params.svh"

package tcdm_pkg;

  typedef logic [31:0] tcdm_addr_t;  // byte address
  typedef logic [31:0] tcdm_word_t;
  typedef logic [3:0]  tcdm_be_t;

  // bank index, doubles as rotation order of a wide access
  typedef logic [$clog2(`TCDM_NB_BANKS)-1:0] bank_sel_t;

  // word row inside one bank
  typedef logic [$clog2(`TCDM_BANK_WORDS)-1:0] row_t;

  // single word request, wen high means read
  typedef struct packed {
    tcdm_addr_t add;
    logic       wen;
    tcdm_be_t   be;
    tcdm_word_t data;
  } word_req_t;

  // wide request, lanes cover consecutive words from add
  typedef struct packed {
    tcdm_addr_t                        add;
    logic                              wen;
    tcdm_be_t   [`TCDM_NB_LANES-1:0] be;
    tcdm_word_t [`TCDM_NB_LANES-1:0] data;
  } wide_req_t;

  // read data of a wide access, lane 0 is the start word
  typedef struct packed {
    tcdm_word_t [`TCDM_NB_LANES-1:0] r_data;
  } wide_rsp_t;

  // who gets the bank read data in the next cycle
  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_WIDE,
    OWNER_NARROW
  } owner_e;

endpackage

/* logic/tcdm_subsystem.sv */
// **************************************
// banked scratchpad with a wide and a narrow port
// top level that wires the splitter, the reorder block and the banks
// **************************************

`timescale 1ns/1ns

`include "tcdm_params.svh"

module tcdm_subsystem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tcdm_pkg::wide_req_t  wide_req_i,
  input  logic                 wide_req_valid_i,
  output logic                 wide_gnt_o,
  output tcdm_pkg::wide_rsp_t  wide_rsp_o,
  output logic                 wide_r_valid_o,
  input  tcdm_pkg::word_req_t  nar_req_i,
  input  logic                 nar_req_valid_i,
  output logic                 nar_gnt_o,
  output tcdm_pkg::tcdm_word_t nar_rdata_o,
  output logic                 nar_r_valid_o
);

  import tcdm_pkg::*;

  word_req_t  [`TCDM_NB_LANES-1:0] lane_req;
  logic       [`TCDM_NB_LANES-1:0] lane_valid;
  bank_sel_t                       order;

  word_req_t  [`TCDM_NB_BANKS-1:0] bank_req;    // wide lane per bank
  logic       [`TCDM_NB_BANKS-1:0] bank_valid;
  logic       [`TCDM_NB_BANKS-1:0] bank_gnt;
  tcdm_word_t [`TCDM_NB_BANKS-1:0] bank_rdata;

  bank_sel_t                       nar_bank;
  logic       [`TCDM_NB_BANKS-1:0] nar_valid;
  logic       [`TCDM_NB_BANKS-1:0] nar_gnt;
  logic       [`TCDM_NB_BANKS-1:0] nar_r_valid;
  tcdm_word_t [`TCDM_NB_BANKS-1:0] nar_rdata;

  logic       [`TCDM_NB_BANKS-1:0] mem_en;
  logic       [`TCDM_NB_BANKS-1:0] mem_wen;
  row_t       [`TCDM_NB_BANKS-1:0] mem_row;
  tcdm_be_t   [`TCDM_NB_BANKS-1:0] mem_be;
  tcdm_word_t [`TCDM_NB_BANKS-1:0] mem_wdata;
  tcdm_word_t [`TCDM_NB_BANKS-1:0] mem_rdata;

  wide_port_splitter i_splitter (
    .wide_req_i       ( wide_req_i       ),
    .wide_req_valid_i ( wide_req_valid_i ),
    .lane_req_o       ( lane_req         ),
    .lane_valid_o     ( lane_valid       ),
    .order_o          ( order            )
  );

  lane_reorder i_reorder (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .lane_req_i     ( lane_req       ),
    .lane_valid_i   ( lane_valid     ),
    .order_i        ( order          ),
    .wide_gnt_o     ( wide_gnt_o     ),
    .wide_rsp_o     ( wide_rsp_o     ),
    .wide_r_valid_o ( wide_r_valid_o ),
    .bank_req_o     ( bank_req       ),
    .bank_valid_o   ( bank_valid     ),
    .bank_gnt_i     ( bank_gnt       ),
    .bank_rdata_i   ( bank_rdata     )
  );

  // narrow word goes to exactly one bank
  assign nar_bank = nar_req_i.add[2 +: $bits(bank_sel_t)];

  for (genvar k = 0; k < `TCDM_NB_BANKS; k++) begin : gen_bank
    assign nar_valid[k] = nar_req_valid_i & (nar_bank == bank_sel_t'(k));

    bank_mux i_mux (
      .clk_i         ( clk_i          ),
      .rst_ni        ( rst_ni         ),
      .wide_req_i    ( bank_req[k]    ),
      .wide_valid_i  ( bank_valid[k]  ),
      .wide_gnt_o    ( bank_gnt[k]    ),
      .wide_rdata_o  ( bank_rdata[k]  ),
      .nar_req_i     ( nar_req_i      ),
      .nar_valid_i   ( nar_valid[k]   ),
      .nar_gnt_o     ( nar_gnt[k]     ),
      .nar_rdata_o   ( nar_rdata[k]   ),
      .nar_r_valid_o ( nar_r_valid[k] ),
      .mem_en_o      ( mem_en[k]      ),
      .mem_wen_o     ( mem_wen[k]     ),
      .mem_row_o     ( mem_row[k]     ),
      .mem_be_o      ( mem_be[k]      ),
      .mem_wdata_o   ( mem_wdata[k]   ),
      .mem_rdata_i   ( mem_rdata[k]   )
    );

    tcdm_bank i_bank (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .en_i    ( mem_en[k]    ),
      .wen_i   ( mem_wen[k]   ),
      .row_i   ( mem_row[k]   ),
      .be_i    ( mem_be[k]    ),
      .wdata_i ( mem_wdata[k] ),
      .rdata_o ( mem_rdata[k] )
    );
  end

  assign nar_gnt_o     = |nar_gnt;
  assign nar_r_valid_o = |nar_r_valid;

  // data from the bank holding the pending narrow response
  always_comb begin
    nar_rdata_o = '0;
    for (int k = 0; k < `TCDM_NB_BANKS; k++) begin
      if (nar_r_valid[k]) begin
        nar_rdata_o = nar_rdata[k];
      end
    end
  end

endmodule

/* logic/wide_port_splitter.sv */
// **************************************
// splits a wide request into per-lane word requests
// also yields the bank of the start word as rotation order
// **************************************

`timescale 1ns/1ns

`include "tcdm_params.svh"

module wide_port_splitter (
  input  tcdm_pkg::wide_req_t                     wide_req_i,
  input  logic                                    wide_req_valid_i,
  output tcdm_pkg::word_req_t [`TCDM_NB_LANES-1:0] lane_req_o,
  output logic                [`TCDM_NB_LANES-1:0] lane_valid_o,
  output tcdm_pkg::bank_sel_t                     order_o
);

  import tcdm_pkg::*;

  tcdm_addr_t start_word;  // word index of lane 0

  assign start_word = wide_req_i.add >> 2;

  // low bits of the word index pick the bank
  assign order_o = start_word[$bits(bank_sel_t)-1:0];

  always_comb begin
    for (int i = 0; i < `TCDM_NB_LANES; i++) begin
      // consecutive words, each lane carries its own address
      lane_req_o[i].add  = wide_req_i.add + tcdm_addr_t'(4 * i);
      lane_req_o[i].wen  = wide_req_i.wen;  // same direction on all lanes
      lane_req_o[i].be   = wide_req_i.be[i];
      lane_req_o[i].data = wide_req_i.data[i];
    end
  end

  // every lane requests together, the grant is all or nothing
  assign lane_valid_o = {`TCDM_NB_LANES{wide_req_valid_i}};

  // initiator contract, sub-word starts would break the rotation
  always_comb begin
    if (wide_req_valid_i) begin
      assert (wide_req_i.add[1:0] == 2'b00)
        else $error("wide request at unaligned address %h", wide_req_i.add);
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the scratchpad testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tcdm_wide_port.f \
  --top-module tcdm_subsystem_tb -o tcdm_sim

# a failing run still prints, the search below decides
out=$(./obj_dir/tcdm_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1

/* tcdm_wide_port.f */
+incdir+logic
logic/tcdm_pkg.sv
logic/wide_port_splitter.sv
logic/lane_reorder.sv
logic/bank_mux.sv
logic/tcdm_bank.sv
logic/tcdm_subsystem.sv
verification/tcdm_subsystem_tb.sv

/* verification/tcdm_subsystem_tb.sv */
// ****************************************
// testbench of the banked scratchpad
// drives the wide and narrow ports and checks every
// response against a shadow memory
// ****************************************

`timescale 1ns/1ns

`include "tcdm_params.svh"

module tcdm_subsystem_tb;

  import tcdm_pkg::*;

  localparam int num_words = `TCDM_NB_BANKS * `TCDM_BANK_WORDS;
  localparam int nb_lanes  = `TCDM_NB_LANES;

  typedef logic [$clog2(num_words)-1:0] widx_t;  // word index over all banks

  logic       clk_i;
  logic       rst_ni;
  wide_req_t  wide_req;
  logic       wide_req_valid;
  logic       wide_gnt;
  wide_rsp_t  wide_rsp;
  logic       wide_r_valid;
  word_req_t  nar_req;
  logic       nar_req_valid;
  logic       nar_gnt;
  tcdm_word_t nar_rdata;
  logic       nar_r_valid;

  tcdm_word_t shadow [num_words];  // reference memory
  logic       nar_read_q [$];
  tcdm_word_t nar_exp_q [$];
  logic       wide_read_q [$];
  wide_rsp_t  wide_exp_q [$];
  logic       nar_gnt_q;   // access accepted one cycle before
  logic       wide_gnt_q;
  int         seed = 32'h168b_743f;

  tcdm_subsystem UUT (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .wide_req_i       ( wide_req       ),
    .wide_req_valid_i ( wide_req_valid ),
    .wide_gnt_o       ( wide_gnt       ),
    .wide_rsp_o       ( wide_rsp       ),
    .wide_r_valid_o   ( wide_r_valid   ),
    .nar_req_i        ( nar_req        ),
    .nar_req_valid_i  ( nar_req_valid  ),
    .nar_gnt_o        ( nar_gnt        ),
    .nar_rdata_o      ( nar_rdata      ),
    .nar_r_valid_o    ( nar_r_valid    )
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // expected word after a byte-enable write
  function automatic tcdm_word_t merge_word(tcdm_word_t old_word, tcdm_word_t new_word,
                                            tcdm_be_t be);
    tcdm_word_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcdm_word_t fill_pattern(widx_t w);
    return (tcdm_word_t'(w) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
  endfunction

  function automatic tcdm_word_t rand_word();
    rand_word = $random(seed);
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input tcdm_word_t got, input tcdm_word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_wide(input string name, input wide_rsp_t got, input wide_rsp_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_nar_gnt();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (nar_gnt !== 1'b1 && cycles < 50) begin
      @(negedge clk_i);
      cycles++;
    end
    if (nar_gnt !== 1'b1) begin
      $display("narrow port got no grant within 50 cycles, at %0t", $time);
      abort_run();
    end
  endtask

  task automatic wait_wide_gnt();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (wide_gnt !== 1'b1 && cycles < 50) begin
      @(negedge clk_i);
      cycles++;
    end
    if (wide_gnt !== 1'b1) begin
      $display("wide port got no grant within 50 cycles, at %0t", $time);
      abort_run();
    end
  endtask

  task automatic drive_narrow(input logic is_read, input widx_t widx, input tcdm_be_t be,
                              input tcdm_word_t data);
    nar_req.add   = tcdm_addr_t'(widx) << 2;
    nar_req.wen   = is_read;  // high means read
    nar_req.be    = be;
    nar_req.data  = data;
    nar_req_valid = 1'b1;
  endtask

  task automatic drive_wide(input logic is_read, input widx_t start,
                            input tcdm_be_t [nb_lanes-1:0] be,
                            input tcdm_word_t [nb_lanes-1:0] data);
    wide_req.add   = tcdm_addr_t'(start) << 2;
    wide_req.wen   = is_read;
    wide_req.be    = be;
    wide_req.data  = data;
    wide_req_valid = 1'b1;
  endtask

  // shadow update and expectation at the accepting edge
  task automatic accept_narrow(input logic is_read, input widx_t widx, input tcdm_be_t be,
                               input tcdm_word_t data);
    if (!is_read) begin
      shadow[widx] = merge_word(shadow[widx], data, be);
    end
    nar_read_q.push_back(is_read);
    nar_exp_q.push_back(shadow[widx]);
  endtask

  task automatic accept_wide(input logic is_read, input widx_t start,
                             input tcdm_be_t [nb_lanes-1:0] be,
                             input tcdm_word_t [nb_lanes-1:0] data);
    widx_t     w;
    wide_rsp_t exp_rsp;
    for (int i = 0; i < nb_lanes; i++) begin
      w = start + widx_t'(i);
      if (!is_read) begin
        shadow[w] = merge_word(shadow[w], data[i], be[i]);
      end
      exp_rsp.r_data[i] = shadow[w];  // lane order whatever the start bank
    end
    wide_read_q.push_back(is_read);
    wide_exp_q.push_back(exp_rsp);
  endtask

  task automatic narrow_access(input logic is_read, input widx_t widx, input tcdm_be_t be,
                               input tcdm_word_t data);
    drive_narrow(is_read, widx, be, data);
    wait_nar_gnt();
    accept_narrow(is_read, widx, be, data);
    @(posedge clk_i);
    #2;
    nar_req_valid = 1'b0;
  endtask

  task automatic wide_access(input logic is_read, input widx_t start,
                             input tcdm_be_t [nb_lanes-1:0] be,
                             input tcdm_word_t [nb_lanes-1:0] data);
    drive_wide(is_read, start, be, data);
    wait_wide_gnt();
    accept_wide(is_read, start, be, data);
    @(posedge clk_i);
    #2;
    wide_req_valid = 1'b0;
  endtask

  // narrow write hits lane 1 of a wide write raised in the same cycle
  task automatic contend_write(input widx_t start);
    tcdm_be_t   [nb_lanes-1:0] lane_be;
    tcdm_word_t [nb_lanes-1:0] lane_data;
    widx_t                     hit;
    tcdm_word_t                nar_data;
    hit = start + widx_t'(1);
    for (int i = 0; i < nb_lanes; i++) begin
      lane_be[i]   = 4'hf;
      lane_data[i] = rand_word();
    end
    lane_be[1] = 4'b0011;  // wide only overwrites the low half
    nar_data   = rand_word();
    drive_wide(1'b0, start, lane_be, lane_data);
    drive_narrow(1'b0, hit, 4'hf, nar_data);
    @(negedge clk_i);
    check_bit("nar_gnt_o", nar_gnt, 1'b1);
    check_bit("wide_gnt_o", wide_gnt, 1'b0);
    accept_narrow(1'b0, hit, 4'hf, nar_data);
    @(posedge clk_i);
    #2;
    nar_req_valid = 1'b0;
    wait_wide_gnt();  // replayed wide access goes through now
    accept_wide(1'b0, start, lane_be, lane_data);
    @(posedge clk_i);
    #2;
    wide_req_valid = 1'b0;
    narrow_access(1'b1, hit, 4'h0, '0);
    wide_access(1'b1, start, '0, '0);
  endtask

  // r_valid one cycle after each accepted access and read data checks
  always @(negedge clk_i) begin : compare_responses
    logic       is_read;
    tcdm_word_t exp_word;
    wide_rsp_t  exp_rsp;
    check_bit("nar_r_valid_o", nar_r_valid, nar_gnt_q);
    check_bit("wide_r_valid_o", wide_r_valid, wide_gnt_q);
    if (nar_r_valid === 1'b1) begin
      is_read  = nar_read_q.pop_front();
      exp_word = nar_exp_q.pop_front();
      if (is_read) begin
        check_word("nar_rdata_o", nar_rdata, exp_word);
      end
    end
    if (wide_r_valid === 1'b1) begin
      is_read = wide_read_q.pop_front();
      exp_rsp = wide_exp_q.pop_front();
      if (is_read) begin
        check_wide("wide_rsp_o", wide_rsp, exp_rsp);
      end
    end
    nar_gnt_q  = (nar_req_valid === 1'b1) && (nar_gnt === 1'b1);
    wide_gnt_q = (wide_req_valid === 1'b1) && (wide_gnt === 1'b1);
  end

  initial begin : stimulus
    widx_t                     addr_list [$];
    widx_t                     widx;
    tcdm_be_t   [nb_lanes-1:0] lane_be;
    tcdm_word_t [nb_lanes-1:0] lane_data;
    int                        start;
    int                        cycles;
    wide_req       = '0;
    wide_req_valid = 1'b0;
    nar_req        = '0;
    nar_req_valid  = 1'b0;
    nar_gnt_q      = 1'b0;
    wide_gnt_q     = 1'b0;
    rst_ni         = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (5) @(posedge clk_i);  // r_valid has to stay low while idle
    #2;

    // known contents everywhere before any read
    for (int s = 0; s < num_words; s += nb_lanes) begin
      for (int i = 0; i < nb_lanes; i++) begin
        lane_be[i]   = 4'hf;
        lane_data[i] = fill_pattern(widx_t'(s + i));
      end
      wide_access(1'b0, widx_t'(s), lane_be, lane_data);
    end

    // narrow writes with random byte enables and read back
    for (int n = 0; n < 40; n++) begin
      widx = widx_t'(rand_word());
      addr_list.push_back(widx);
      narrow_access(1'b0, widx, tcdm_be_t'(rand_word()), rand_word());
    end
    while (addr_list.size() > 0) begin
      narrow_access(1'b1, addr_list.pop_front(), 4'h0, '0);
    end

    // wide writes from every start bank with wrap into the next row
    for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
      start = `TCDM_NB_BANKS * (20 + 2 * b) + b;
      for (int i = 0; i < nb_lanes; i++) begin
        lane_be[i]   = tcdm_be_t'(rand_word());
        lane_data[i] = rand_word();
      end
      wide_access(1'b0, widx_t'(start), lane_be, lane_data);
      for (int i = 0; i < nb_lanes; i++) begin
        narrow_access(1'b1, widx_t'(start + i), 4'h0, '0);
      end
    end

    // wide reads at random aligned word addresses
    for (int n = 0; n < 30; n++) begin
      start = int'(rand_word() % (num_words - nb_lanes + 1));
      wide_access(1'b1, widx_t'(start), '0, '0);
    end

    contend_write(widx_t'(`TCDM_NB_BANKS * 40 + 2));
    contend_write(widx_t'(`TCDM_NB_BANKS * 41 + 6));
    contend_write(widx_t'(`TCDM_NB_BANKS * 42 + 7));  // lane 1 in the next row

    // drain the last responses
    cycles = 0;
    while ((nar_read_q.size() + wide_read_q.size()) > 0 && cycles < 50) begin
      @(posedge clk_i);
      cycles++;
    end
    if ((nar_read_q.size() + wide_read_q.size()) > 0) begin
      $display("responses still missing 50 cycles after the last access");
      abort_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule
